// File: testbench/decode_stimulus.txt
// name instr rs1 rs2 rd funct3 funct7 opcode alu_op imm_signed imm_unsigned
// All columns after the name are hex, alu_op is the alu_op_e code
add         006283b3 05 06 07 0 00 33 00 00000000 00000000
sub         406283b3 05 06 07 0 20 33 01 00000000 00000000
sll         006293b3 05 06 07 1 00 33 05 00000000 00000000
slt         0062a3b3 05 06 07 2 00 33 11 00000000 00000000
sltu        0062b3b3 05 06 07 3 00 33 08 00000000 00000000
xor         0062c3b3 05 06 07 4 00 33 04 00000000 00000000
srl         0062d3b3 05 06 07 5 00 33 06 00000000 00000000
sra         4062d3b3 05 06 07 5 20 33 07 00000000 00000000
or          0062e3b3 05 06 07 6 00 33 03 00000000 00000000
and         0062f3b3 05 06 07 7 00 33 02 00000000 00000000
addi_pos    00510093 02 00 01 0 00 13 00 00000005 00000000
addi_neg    fff10093 02 00 01 0 00 13 00 ffffffff 00000000
addi_min    80010093 02 00 01 0 00 13 00 fffff800 00000000
sltiu       7ff23193 04 00 03 3 00 13 08 000007ff 00000000
srai        40335293 06 00 05 5 00 13 07 00000403 00000000
srli_sh33   02135293 06 00 05 5 00 13 06 00000021 00000000
addiw_neg   ffd4039b 08 00 07 0 00 1b 00 fffffffd 00000000
srliw       0045549b 0a 00 09 5 00 1b 06 00000004 00000000
jalr        010280e7 05 00 01 0 00 67 00 00000010 00000000
ld_neg      ff813503 02 00 0a 3 00 03 00 fffffff8 00000000
lbu         0ff64583 0c 00 0b 4 00 03 00 000000ff 00000000
sd          00513c23 02 05 00 3 00 23 00 00000018 00000000
sw_neg      fe61ae23 03 06 00 2 00 23 00 fffffffc 00000000
beq         00208863 01 02 00 0 00 63 0a 00000010 00000010
bne_neg     fe419ce3 03 04 00 1 00 63 0b fffffff8 00001ff8
blt         0062c0e3 05 06 00 4 00 63 0c 00000800 00000800
bge_neg     8083d063 07 08 00 5 00 63 0d fffff000 00001000
bltu        00a4e263 09 0a 00 6 00 63 0e 00000004 00000004
bgeu_neg    fec5ffe3 0b 0c 00 7 00 63 0f fffffffe 00001ffe
lui         123452b7 00 00 05 0 00 37 09 12345000 00000000
lui_neg     fffff337 00 00 06 0 00 37 09 fffff000 00000000
auipc       80000397 00 00 07 0 00 17 00 80000000 00000000
jal_fwd     001000ef 00 00 01 0 00 6f 10 00000800 00000000
jal_back    ffdff06f 00 00 00 0 00 6f 10 fffffffc 00000000
bad_opcode  ffffffff 00 00 00 0 00 7f 11 00000000 00000000
load_bad_f3 0ff67583 0c 00 0b 7 00 03 11 000000ff 00000000

// File: files.f
hdl/rv_isa_pkg.sv
hdl/id_pkg.sv
hdl/inst_format_decode.sv
hdl/imm_gen.sv
hdl/alu_ctrl.sv
hdl/decoder_id_stage.sv
testbench/tb_decoder_id_stage.sv

// File: Bender.yml
package:
  name: decoder_id_stage

sources:
  - hdl/rv_isa_pkg.sv
  - hdl/id_pkg.sv
  - hdl/inst_format_decode.sv
  - hdl/imm_gen.sv
  - hdl/alu_ctrl.sv
  - hdl/decoder_id_stage.sv
  - target: test
    files:
      - testbench/tb_decoder_id_stage.sv

// File: testbench/tb_decoder_id_stage.sv
module tb_decoder_id_stage
    import rv_isa_pkg::*;
    import id_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int    wait_limit = 20;  // Cycles a drain may take
    localparam string stim_path  = "testbench/decode_stimulus.txt";

    // One line of the vector file
    typedef struct packed {
        logic [31:0] instr;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [6:0]  opcode;
        logic [4:0]  alu_op;        // alu_op_e code
        logic [31:0] imm_signed;
        logic [31:0] imm_unsigned;
    } vec_t;

    // Instruction in flight through the ID register
    typedef struct packed {
        int unsigned idx;        // Into vecs
        int unsigned due_cycle;  // Edge count where the result must show
        int unsigned stream;     // 1 back-to-back or 2 gapped
    } pend_t;

    logic               clk;
    logic               rst;
    logic               instr_valid;
    logic [instr_w-1:0] instr;
    logic               id_valid;
    id_decoded_t        id_out;

    vec_t  vecs[$];
    string names[$];
    pend_t pending[$];      // Expected results with the oldest first

    int unsigned cycle_cnt  = 0;
    logic        prev_valid = 1'b0;  // instr_valid seen at the last edge
    bit          checking   = 1'b0;
    int          last_idx   = -1;    // Last result the register should hold
    int          field_errs = 0;
    int          pass_cnt   = 0;
    int          fail_cnt   = 0;
    bit          aborted    = 1'b0;

    decoder_id_stage i_dut (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .id_valid    (id_valid),
        .id_out      (id_out)
    );

    always #4 clk = ~clk;  // 8 ns period

    always @(posedge clk) begin
        cycle_cnt  <= cycle_cnt + 1;
        prev_valid <= instr_valid;
    end

    task automatic check_field(input string test, input string field,
                               input logic [31:0] expv, input logic [31:0] actv);
        assert (actv === expv) else begin
            $display("ERR %s %s expected %08h actual %08h", test, field, expv, actv);
            field_errs++;
        end
    endtask

    // Every field of the registered output against one vector
    task automatic check_all(input string test, input vec_t v);
        check_field(test, "rs1", v.rs1, id_out.rs1);
        check_field(test, "rs2", v.rs2, id_out.rs2);
        check_field(test, "rd", v.rd, id_out.rd);
        check_field(test, "funct3", v.funct3, id_out.funct3);
        check_field(test, "funct7", v.funct7, id_out.funct7);
        check_field(test, "opcode", v.opcode, id_out.opcode);
        check_field(test, "alu_op", v.alu_op, id_out.alu_op);
        check_field(test, "imm_signed", v.imm_signed, id_out.imm_signed);
        check_field(test, "imm_unsigned", v.imm_unsigned, id_out.imm_unsigned);
    endtask

    // Sampled mid-cycle away from both edges
    always @(negedge clk) begin : check_outputs
        pend_t p;
        int    errs_before;
        string label;
        if (checking) begin
            assert (id_valid === prev_valid) else begin
                $display("ERR valid_delay id_valid expected %b actual %b",
                         prev_valid, id_valid);
                fail_cnt++;
            end
            if (id_valid === 1'b1) begin
                if (pending.size() == 0) begin
                    $display("id_valid went high with no instruction outstanding");
                    fail_cnt++;
                end else begin
                    p           = pending.pop_front();
                    label       = $sformatf("s%0d_%s", p.stream, names[p.idx]);
                    errs_before = field_errs;
                    check_field(label, "cycle", p.due_cycle, cycle_cnt);  // One-cycle latency
                    check_all(label, vecs[p.idx]);
                    last_idx = p.idx;
                    if (field_errs == errs_before) begin
                        pass_cnt++;
                        $display("%s: ok", label);
                    end else begin
                        fail_cnt++;
                        $display("%s: mismatch", label);
                    end
                end
            end else if (last_idx >= 0) begin
                // Register keeps the last result over a bubble
                errs_before = field_errs;
                check_all($sformatf("hold_%s", names[last_idx]), vecs[last_idx]);
                if (field_errs != errs_before) fail_cnt++;
            end
        end
    end

    task automatic load_vectors(output bit ok);
        int          fd;
        int          n;
        string       line;
        string       name;
        logic [31:0] w_instr;
        logic [31:0] w_rs1;
        logic [31:0] w_rs2;
        logic [31:0] w_rd;
        logic [31:0] w_f3;
        logic [31:0] w_f7;
        logic [31:0] w_op;
        logic [31:0] w_alu;
        logic [31:0] w_imm_s;
        logic [31:0] w_imm_u;
        vec_t        v;
        ok = 1'b0;
        fd = $fopen(stim_path, "r");
        if (fd == 0) begin
            $display("Could not open the vector file %s", stim_path);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n    = $fgets(line, fd);
                // Skip blanks and comment lines
                if (n > 0 && line.len() > 1 && line.substr(0, 1) != "//") begin
                    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h", name, w_instr,
                                w_rs1, w_rs2, w_rd, w_f3, w_f7, w_op, w_alu, w_imm_s, w_imm_u);
                    if (n == 11) begin
                        v.instr        = w_instr;
                        v.rs1          = w_rs1[4:0];
                        v.rs2          = w_rs2[4:0];
                        v.rd           = w_rd[4:0];
                        v.funct3       = w_f3[2:0];
                        v.funct7       = w_f7[6:0];
                        v.opcode       = w_op[6:0];
                        v.alu_op       = w_alu[4:0];
                        v.imm_signed   = w_imm_s;
                        v.imm_unsigned = w_imm_u;
                        vecs.push_back(v);
                        names.push_back(name);
                    end else begin
                        $display("Skipping malformed vector line: %s", line);
                    end
                end
            end
            $fclose(fd);
            ok = (vecs.size() > 0);
            if (!ok) $display("No vectors found in %s", stim_path);
        end
    endtask

    // Three edges with rst high and one idle edge after release
    task automatic reset_check();
        int errs_before;
        errs_before = field_errs;
        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
            #1;
            check_field("reset", "id_valid", 32'd0, {31'd0, id_valid});
            check_field("reset", "id_out_nonzero", 32'd0, {31'd0, |id_out});
        end
        rst = 1'b0;
        @(posedge clk);
        #1;
        check_field("after_reset", "id_valid", 32'd0, {31'd0, id_valid});
        check_field("after_reset", "id_out_nonzero", 32'd0, {31'd0, |id_out});
        if (field_errs == errs_before) begin
            pass_cnt++;
            $display("reset: ok");
        end else begin
            fail_cnt++;
            $display("reset: mismatch");
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        instr       = $urandom;  // Junk on the bus must not load
    endtask

    task automatic stream_vectors(input int unsigned stream, input bit gapped);
        int unsigned gap;
        pend_t       p;
        for (int i = 0; i < vecs.size(); i++) begin
            if (gapped) begin
                gap = $urandom_range(3, 0);
                repeat (gap) idle_cycle();
            end
            @(posedge clk);
            #1;
            instr       = vecs[i].instr;
            instr_valid = 1'b1;
            p.idx       = i;
            p.due_cycle = cycle_cnt + 1;  // Sampled at the next edge
            p.stream    = stream;
            pending.push_back(p);
        end
        idle_cycle();
    endtask

    task automatic wait_drain();
        int cnt;
        cnt = 0;
        while (pending.size() != 0 && cnt < wait_limit) begin
            @(posedge clk);
            cnt++;
        end
        if (pending.size() != 0) begin
            $display("Timeout: %0d instructions never came out with id_valid within %0d cycles",
                     pending.size(), wait_limit);
            fail_cnt += pending.size();
            aborted = 1'b1;
        end
    endtask

    initial begin
        bit opened;
        clk         = 1'b0;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        void'($urandom(32'h0af6_570f));
        load_vectors(opened);
        if (opened) begin
            reset_check();
            checking = 1'b1;
            stream_vectors(1, 1'b0);  // Back to back
            wait_drain();
            if (!aborted) begin
                stream_vectors(2, 1'b1);  // Random bubbles
                wait_drain();
            end
        end else begin
            aborted = 1'b1;
        end
        $display("Summary: %0d tests ok, %0d tests failed", pass_cnt, fail_cnt);
        if (!aborted && fail_cnt == 0 && field_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: hdl/decoder_id_stage.sv
module decoder_id_stage
    import rv_isa_pkg::*;
    import id_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               instr_valid,
    input  logic [instr_w-1:0] instr,
    output logic               id_valid,
    output id_decoded_t        id_out
);

    inst_fields_t      fields_raw;   // Instruction viewed as fields
    inst_fields_t      fields_clr;   // After format clearing
    inst_fmt_e         fmt;
    logic [xlen_w-1:0] imm_signed;
    logic [xlen_w-1:0] imm_unsigned;
    alu_op_e           alu_op;
    id_decoded_t       id_next;      // Register input

    assign fields_raw = inst_fields_t'(instr);

    inst_format_decode i_fmt (
        .fields_in  (fields_raw),
        .fmt        (fmt),
        .fields_out (fields_clr)
    );

    imm_gen i_imm (
        .instr        (instr),
        .fmt          (fmt),
        .imm_signed   (imm_signed),
        .imm_unsigned (imm_unsigned)
    );

    // Raw funct bits, the cleared copies lose shift info
    alu_ctrl i_alu_ctrl (
        .fmt    (fmt),
        .opcode (fields_raw.opcode),
        .funct3 (fields_raw.funct3),
        .funct7 (fields_raw.funct7),
        .alu_op (alu_op)
    );

    always_comb begin
        id_next.rs1          = fields_clr.rs1;
        id_next.rs2          = fields_clr.rs2;
        id_next.rd           = fields_clr.rd;
        id_next.funct3       = fields_clr.funct3;
        id_next.funct7       = fields_clr.funct7;
        id_next.opcode       = fields_clr.opcode;
        id_next.alu_op       = alu_op;
        id_next.imm_signed   = imm_signed;
        id_next.imm_unsigned = imm_unsigned;
    end

    // ID pipeline register, one instruction deep
    always_ff @(posedge clk) begin
        if (rst) begin
            id_valid <= 1'b0;
            id_out   <= '0;
        end else begin
            id_valid <= instr_valid;   // Bubble follows an idle cycle
            if (instr_valid) begin
                id_out <= id_next;     // Holds last value otherwise
            end
        end
    end

endmodule

// File: hdl/alu_ctrl.sv
module alu_ctrl
    import rv_isa_pkg::*;
    import id_pkg::*;
(
    input  inst_fmt_e  fmt,
    input  opcode_e    opcode,
    input  logic [2:0] funct3,
    input  logic [6:0] funct7,   // Raw, shifts need bit 30
    output alu_op_e    alu_op
);

    logic f7_zero;   // funct7 all zero
    logic f7_alt;    // funct7 == 0100000, SUB/SRA
    logic shamt6_ok; // RV64 shift by imm, funct7[0] is shamt[5]

    assign f7_zero   = (funct7 == 7'b0000000);
    assign f7_alt    = (funct7 == 7'b0100000);
    assign shamt6_ok = (funct7[6] == 1'b0) && (funct7[4:1] == 4'b0000);

    always_comb begin
        alu_op = ALU_NONE;  // Anything unmatched
        case (fmt)
            FMT_R: begin
                case (funct3)
                    3'b000: begin
                        if (f7_zero)     alu_op = ALU_ADD;
                        else if (f7_alt) alu_op = ALU_SUB;
                    end
                    3'b001: if (f7_zero) alu_op = ALU_SLL;
                    3'b011: if (f7_zero) alu_op = ALU_SLTU;
                    3'b100: if (f7_zero) alu_op = ALU_XOR;
                    3'b101: begin
                        if (f7_zero)     alu_op = ALU_SRL;
                        else if (f7_alt) alu_op = ALU_SRA;
                    end
                    3'b110: if (f7_zero) alu_op = ALU_OR;
                    3'b111: if (f7_zero) alu_op = ALU_AND;
                    default: ;          // SLT not supported
                endcase
            end
            FMT_I: begin
                case (opcode)
                    OP_I_ALU: begin
                        case (funct3)
                            3'b000: alu_op = ALU_ADD;
                            3'b001: if (funct7[6:1] == 6'b0) alu_op = ALU_SLL;
                            3'b011: alu_op = ALU_SLTU;
                            3'b100: alu_op = ALU_XOR;
                            3'b101: begin
                                // Bit 30 picks arithmetic shift
                                if (shamt6_ok) alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                            end
                            3'b110: alu_op = ALU_OR;
                            3'b111: alu_op = ALU_AND;
                            default: ;  // SLTI
                        endcase
                    end
                    OP_I_W: begin
                        // Word shifts have 5-bit shamt, funct7 fully checked
                        case (funct3)
                            3'b000: alu_op = ALU_ADD;
                            3'b001: if (f7_zero) alu_op = ALU_SLL;
                            3'b101: begin
                                if (f7_zero)     alu_op = ALU_SRL;
                                else if (f7_alt) alu_op = ALU_SRA;
                            end
                            default: ;
                        endcase
                    end
                    OP_JALR: if (funct3 == 3'b000) alu_op = ALU_ADD;  // Target address
                    OP_LOAD: if (funct3 != 3'b111) alu_op = ALU_ADD;  // Effective address
                    default: ;
                endcase
            end
            FMT_S: if (funct3[2] == 1'b0) alu_op = ALU_ADD;  // SB..SD
            FMT_B: begin
                case (funct3)
                    3'b000:  alu_op = ALU_BEQ;
                    3'b001:  alu_op = ALU_BNE;
                    3'b100:  alu_op = ALU_BLT;
                    3'b101:  alu_op = ALU_BGE;
                    3'b110:  alu_op = ALU_BLTU;
                    3'b111:  alu_op = ALU_BGEU;
                    default: ;
                endcase
            end
            FMT_U: alu_op = (opcode == OP_LUI) ? ALU_PASS : ALU_ADD;  // AUIPC adds PC
            FMT_J: alu_op = ALU_LINK;
            default: ;  // FMT_NONE
        endcase
    end

endmodule

// File: hdl/imm_gen.sv
module imm_gen
    import rv_isa_pkg::*;
    import id_pkg::*;
(
    input  logic [instr_w-1:0] instr,
    input  inst_fmt_e          fmt,
    output logic [xlen_w-1:0]  imm_signed,
    output logic [xlen_w-1:0]  imm_unsigned
);

    logic        sign;     // Immediate sign, always instr[31]
    logic [12:0] b_off;    // Branch offset before extension

    assign sign  = instr[31];
    // Scattered B-type bits, LSB implied zero
    assign b_off = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        case (fmt)
            FMT_I:   imm_signed = {{(xlen_w - 12){sign}}, instr[31:20]};
            FMT_S:   imm_signed = {{(xlen_w - 12){sign}}, instr[31:25], instr[11:7]};
            FMT_B:   imm_signed = {{(xlen_w - 13){sign}}, b_off};
            FMT_U:   imm_signed = {instr[31:12], 12'b0};  // Upper 20 bits
            FMT_J: begin
                // imm[20|10:1|11|19:12] in the word
                imm_signed = {{(xlen_w - 21){sign}}, instr[31], instr[19:12],
                              instr[20], instr[30:21], 1'b0};
            end
            default: imm_signed = '0;  // FMT_R, FMT_NONE
        endcase
    end

    // Zero-extended offset for BLTU/BGEU consumers
    always_comb begin
        if (fmt == FMT_B) begin
            imm_unsigned = {{(xlen_w - 13){1'b0}}, b_off};
        end else begin
            imm_unsigned = '0;
        end
    end

endmodule

// File: hdl/inst_format_decode.sv
module inst_format_decode
    import rv_isa_pkg::*;
(
    input  inst_fields_t fields_in,
    output inst_fmt_e    fmt,
    output inst_fields_t fields_out
);

    // Opcode to format
    always_comb begin
        case (fields_in.opcode)
            OP_R:      fmt = FMT_R;
            OP_I_ALU,
            OP_I_W,
            OP_JALR,
            OP_LOAD:   fmt = FMT_I;   // All share the 12-bit immediate
            OP_STORE:  fmt = FMT_S;
            OP_BRANCH: fmt = FMT_B;
            OP_LUI,
            OP_AUIPC:  fmt = FMT_U;
            OP_JAL:    fmt = FMT_J;
            default:   fmt = FMT_NONE;
        endcase
    end

    // Zero fields the format does not carry
    // so the register file never sees stray indices
    always_comb begin
        fields_out = fields_in;  // FMT_R keeps everything
        case (fmt)
            FMT_I: begin
                fields_out.rs2    = '0;  // Immediate bits
                fields_out.funct7 = '0;
            end
            FMT_S,
            FMT_B: begin
                fields_out.rd     = '0;  // Low immediate bits, no writeback
                fields_out.funct7 = '0;
            end
            FMT_U,
            FMT_J: begin
                // Only rd and opcode are real here
                fields_out.rs1    = '0;
                fields_out.rs2    = '0;
                fields_out.funct3 = '0;
                fields_out.funct7 = '0;
            end
            FMT_NONE: begin
                fields_out.rs1    = '0;
                fields_out.rs2    = '0;
                fields_out.rd     = '0;
                fields_out.funct3 = '0;
                fields_out.funct7 = '0;  // Opcode left for debug
            end
            default: ;  // FMT_R
        endcase
    end

endmodule

// File: hdl/id_pkg.sv
package id_pkg;

    import rv_isa_pkg::*;

    // ALU operations handed to EX, one code each
    typedef enum logic [4:0] {
        ALU_ADD,   // Also address calc for loads, stores, JALR, AUIPC
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLTU,
        ALU_PASS,  // LUI, immediate straight through
        ALU_BEQ,
        ALU_BNE,
        ALU_BLT,
        ALU_BGE,
        ALU_BLTU,
        ALU_BGEU,
        ALU_LINK,  // JAL return address
        ALU_NONE   // Unsupported encoding
    } alu_op_e;

    // Contents of the ID pipeline register
    typedef struct packed {
        logic [reg_idx_w-1:0] rs1;
        logic [reg_idx_w-1:0] rs2;
        logic [reg_idx_w-1:0] rd;
        logic [2:0]           funct3;
        logic [6:0]           funct7;
        logic [6:0]           opcode;        // Raw bits, unknown opcodes pass through
        alu_op_e              alu_op;
        logic [xlen_w-1:0]    imm_signed;    // Two's complement
        logic [xlen_w-1:0]    imm_unsigned;  // Branch offset, zero-extended
    } id_decoded_t;

endpackage

// File: hdl/rv_isa_pkg.sv
package rv_isa_pkg;

    // Base widths
    localparam int xlen_w    = 32;  // Immediate width
    localparam int instr_w   = 32;  // Instruction width
    localparam int reg_idx_w = 5;   // x0..x31

    // Major opcodes, standard RISC-V encodings
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,  // LB/LH/LW/LD/LBU/LHU/LWU
        OP_I_ALU  = 7'b0010011,  // ADDI, ANDI, shifts by immediate
        OP_AUIPC  = 7'b0010111,
        OP_I_W    = 7'b0011011,  // RV64 word immediates
        OP_STORE  = 7'b0100011,
        OP_R      = 7'b0110011,  // Register-register ALU
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcode_e;

    // Instruction formats
    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_NONE  // Opcode not recognised
    } inst_fmt_e;

    // Raw fields, MSB first as laid out in the instruction word
    typedef struct packed {
        logic [6:0]           funct7;  // [31:25]
        logic [reg_idx_w-1:0] rs2;     // [24:20]
        logic [reg_idx_w-1:0] rs1;     // [19:15]
        logic [2:0]           funct3;  // [14:12]
        logic [reg_idx_w-1:0] rd;      // [11:7]
        opcode_e              opcode;  // [6:0]
    } inst_fields_t;

endpackage
